// File: tests/fpm_trace.txt
# op a b exp align g wdt wt exp_over exp_under (op 0 AF, 1 SF, 2 MF, 3 DF)
0   10    3    10  7 0 0 0 0 0
1    3   10    10  7 0 1 0 0 0
0    5    5     5  0 0 0 0 0 0
0  -20   -5    -5 15 0 1 0 0 0
1   39    0    39 39 0 0 0 0 0
0  -39    0     0 39 0 1 0 0 0
1  100   70   100 30 0 0 0 0 0
0 -128 -100  -100 28 0 1 0 0 0
1    1    0     1  1 0 0 0 0 0
0   40    0    40  0 1 0 1 0 0
1    0   40    40  0 1 1 0 0 0
0  127 -128   127  0 1 0 1 0 0
1 -128  127   127  0 1 1 0 0 0
0  -50   20    20  0 1 1 0 0 0
1   90  -10    90  0 1 0 1 0 0
2   10   20    30  0 0 0 0 0 0
2  100   27   127  0 0 0 0 0 0
2  100   28   128  0 0 0 0 1 0
2  127  127   254  0 0 0 0 1 0
2 -100  -28  -128  0 0 0 0 0 0
2 -100  -29  -129  0 0 0 0 0 1
2 -128 -128  -256  0 0 0 0 0 1
2   -5    3    -2  0 0 0 0 0 0
3   20    5    15  0 0 0 0 0 0
3  127   -1   128  0 0 0 0 1 0
3  100  -27   127  0 0 0 0 0 0
3 -128    1  -129  0 0 0 0 0 1
3 -100   28  -128  0 0 0 0 0 0
3  127 -128   255  0 0 0 0 1 0
3 -128  127  -255  0 0 0 0 0 1
1   -2   36    36 38 0 1 0 0 0

// File: verilog.f
logic/fpm_pkg.sv
logic/fpm_exp_path.sv
logic/fpm_fic.sv
logic/fpm_indicators.sv
logic/fpm_sequencer.sv
logic/fpm_top.sv
tests/fpm_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fpm_tb -f verilog.f -o fpm_sim

# a $fatal in the testbench gives a failing exit status
./obj_dir/fpm_sim

// File: tests/fpm_tb.sv
// ---------------------------------------------------------------------------
// testbench for the F-PM exponent and control unit
// trace-driven commands over the req/ack handshake
// result, latency and back-pressure checks with ack timeouts
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module fpm_tb import fpm_pkg::*; ();

	localparam int ACK_TIMEOUT = 200;
	localparam int DRIVE_DLY = 2;

	logic     clk_sys;
	logic     _0_f;
	logic     req;
	logic     ack;
	fpm_cmd_t cmd;
	fpm_res_t res;

	// fields of the current trace line
	int op_code;
	int arg_a;
	int arg_b;
	int want_exp;
	int want_align;
	int want_g;
	int want_wdt;
	int want_wt;
	int want_over;
	int want_under;

	fpm_top #(
		.ALIGN_LIMIT (40),
		.FIC_W       (6)
	) UUT (
		.clk_sys (clk_sys),
		._0_f    (_0_f),
		.req     (req),
		.ack     (ack),
		.cmd     (cmd),
		.res     (res)
	);

	always #20 clk_sys = ~clk_sys;

	task automatic fail_now(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual !== expected)
			fail_now($sformatf("FAIL at %0t ns: %s is %0d, expected %0d",
				$time, name, actual, expected));
	endtask

	// drive and sample point just after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#(DRIVE_DLY);
	endtask

	task automatic wait_ack(input logic level, output int cycles);
		cycles = 0;
		while (ack !== level) begin
			if (cycles == ACK_TIMEOUT)
				fail_now($sformatf("timeout: ack did not go to %0b within %0d clock cycles",
					level, ACK_TIMEOUT));
			next_cycle();
			cycles++;
		end
	endtask

	task automatic run_command();
		int gap;
		int hold;
		int cycles;
		fpm_res_t held;

		gap = int'($urandom % 6);
		repeat (gap)
			next_cycle();
		cmd.op = fp_op_e'(op_code[1:0]);
		cmd.exp_a = arg_a[7:0];
		cmd.exp_b = arg_b[7:0];
		req = 1'b1;
		wait_ack(1'b1, cycles);
		// the first edge that saw req is counted too
		check_value("latency", cycles - 1, 4 + want_align);
		check_value("res.exp", int'(res.exp), want_exp);
		check_value("res.align", int'(res.align), want_align);
		check_value("res.g", int'(res.g), want_g);
		check_value("res.wdt", int'(res.wdt), want_wdt);
		check_value("res.wt", int'(res.wt), want_wt);
		check_value("res.exp_over", int'(res.exp_over), want_over);
		check_value("res.exp_under", int'(res.exp_under), want_under);

		// the result must hold under back-pressure
		held = res;
		hold = int'($urandom % 5);
		repeat (hold) begin
			next_cycle();
			check_value("ack", int'(ack), 1);
			check_value("res", int'(res), int'(held));
		end
		req = 1'b0;
		wait_ack(1'b0, cycles);
	endtask

	initial begin
		int fd;
		int n;
		int count;
		logic [8*128-1:0] header;

		clk_sys = 1'b0;
		_0_f = 1'b1;
		req = 1'b0;
		cmd = '0;
		count = 0;
		void'($urandom(85));

		repeat (4)
			@(posedge clk_sys);
		#(DRIVE_DLY);
		_0_f = 1'b0;
		check_value("ack after reset", int'(ack), 0);

		fd = $fopen("tests/fpm_trace.txt", "r");
		if (fd == 0)
			fail_now("could not open the trace file tests/fpm_trace.txt");
		// column header
		n = $fgets(header, fd);

		while (!$feof(fd)) begin
			n = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d\n",
				op_code, arg_a, arg_b, want_exp, want_align,
				want_g, want_wdt, want_wt, want_over, want_under);
			if (n == 10) begin
				if (op_code < 0 || op_code > 3)
					fail_now($sformatf("trace line %0d has an unknown operation %0d",
						count + 1, op_code));
				run_command();
				count++;
			end else if (n > 0) begin
				fail_now($sformatf("trace line %0d is incomplete", count + 1));
			end
		end
		$fclose(fd);

		if (count == 0) begin
			$display("no commands were read from the trace file");
			$display("** FAIL **");
			$fatal(1, "empty trace");
		end else begin
			$display("%0d commands checked", count);
			$display("** PASS **");
			$finish;
		end
	end

endmodule

// File: logic/fpm_top.sv
// ---------------------------------------------------------------------------
// F-PM exponent and control unit, top level
// sequencer, exponent datapath, shift counter and indicators
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module fpm_top import fpm_pkg::*; #(
	parameter int ALIGN_LIMIT = 40,
	parameter int FIC_W = 6
) (
	input  logic     clk_sys,
	input  logic     _0_f,
	input  logic     req,
	output logic     ack,
	input  fpm_cmd_t cmd,
	output fpm_res_t res
);

	fpm_ctl_t          ctl;
	logic signed [9:0] d;
	logic              diff_neg;
	logic [FIC_W-1:0]  diff_abs;
	logic              ge_limit;
	logic              fic_zero;

	fpm_sequencer seq (
		.clk_sys  (clk_sys),
		._0_f     (_0_f),
		.req      (req),
		.op       (cmd.op),
		.ge_limit (ge_limit),
		.fic_zero (fic_zero),
		.ack      (ack),
		.ctl      (ctl)
	);

	fpm_exp_path #(
		.ALIGN_LIMIT (ALIGN_LIMIT),
		.FIC_W       (FIC_W)
	) exp_path (
		.clk_sys  (clk_sys),
		._0_f     (_0_f),
		.cmd      (cmd),
		.ctl      (ctl),
		.d        (d),
		.diff_neg (diff_neg),
		.diff_abs (diff_abs),
		.ge_limit (ge_limit)
	);

	// shift count comes straight from the difference magnitude
	fpm_fic #(.FIC_W(FIC_W)) fic (
		.clk_sys  (clk_sys),
		._0_f     (_0_f),
		.ctl      (ctl),
		.load_val (diff_abs),
		.fic_zero (fic_zero)
	);

	fpm_indicators #(.FIC_W(FIC_W)) ind (
		.clk_sys  (clk_sys),
		._0_f     (_0_f),
		.ctl      (ctl),
		.d        (d),
		.diff_neg (diff_neg),
		.diff_abs (diff_abs),
		.ge_limit (ge_limit),
		.res      (res)
	);

endmodule

// File: logic/fpm_sequencer.sv
// ---------------------------------------------------------------------------
// phase sequencer
// opcode decode, control strobes for the datapath
// req/ack handshake with the host
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module fpm_sequencer import fpm_pkg::*; (
	input  logic     clk_sys,
	input  logic     _0_f,
	input  logic     req,
	input  fp_op_e   op,
	input  logic     ge_limit,
	input  logic     fic_zero,
	output logic     ack,
	output fpm_ctl_t ctl
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOAD_B,
		S_XFER,
		S_SUM,
		S_ALIGN,
		S_FINAL,
		S_DONE
	} phase_e;

	phase_e state;
	phase_e state_next;
	logic   add_sub;
	logic   mul;

	// subtract differs from add only in the mantissa path
	assign add_sub = (op == OP_AF) || (op == OP_SF);
	assign mul = (op == OP_MF);

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE:
				if (req)
					state_next = S_LOAD_B;
			S_LOAD_B:
				state_next = S_XFER;
			S_XFER:
				state_next = S_SUM;
			S_SUM:
				if (add_sub && !ge_limit && !fic_zero)
					state_next = S_ALIGN;
				else
					state_next = S_FINAL;
			S_ALIGN:
				if (fic_zero)
					state_next = S_FINAL;
			S_FINAL:
				state_next = S_DONE;
			S_DONE:
				if (!req)
					state_next = S_IDLE;
			default:
				state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f)
			state <= S_IDLE;
		else
			state <= state_next;
	end

	// ack follows the result and drops once the host lets go of req
	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f)
			ack <= 1'b0;
		else if (state == S_FINAL)
			ack <= 1'b1;
		else if (state == S_DONE && !req)
			ack <= 1'b0;
	end

	always_comb begin
		ctl = '0;
		ctl.bsel = BB_ZERO;
		case (state)
			S_LOAD_B: begin
				ctl.lkb = 1'b1;
				ctl.opnd_b = 1'b1;
				ctl.l_d = 1'b1;
				ctl.clr = 1'b1;
			end
			S_XFER: begin
				ctl.lkb = 1'b1;
				ctl.l_d = 1'b1;
				ctl.l_b = 1'b1;
			end
			S_SUM: begin
				ctl.l_d = 1'b1;
				// multiply adds and the rest subtract B from D
				ctl.bsel = mul ? BB_TRUE : BB_INV;
				ctl.pc8 = ~mul;
				ctl.ind_strobe = add_sub;
				ctl.fic_load = add_sub;
			end
			S_ALIGN:
				ctl.fic_step = 1'b1;
			S_FINAL: begin
				// larger exponent for add and subtract
				ctl.lkb = add_sub;
				ctl.l_d = add_sub;
				ctl.range_strobe = ~add_sub;
			end
			default: begin
			end
		endcase
	end

	a_ack_rise_on_req: assert property (@(posedge clk_sys) disable iff (_0_f)
		$rose(ack) |-> $past(req));

endmodule

// File: logic/fpm_indicators.sv
// ---------------------------------------------------------------------------
// exponent indicators
// g, wdt, wt and alignment count from the difference
// exponent range flags and result assembly
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module fpm_indicators import fpm_pkg::*; #(
	parameter int FIC_W = 6
) (
	input  logic              clk_sys,
	input  logic              _0_f,
	input  fpm_ctl_t          ctl,
	input  logic signed [9:0] d,
	input  logic              diff_neg,
	input  logic [FIC_W-1:0]  diff_abs,
	input  logic              ge_limit,
	output fpm_res_t          res
);

	logic             g;
	logic             wdt;
	logic             wt;
	logic [FIC_W-1:0] align_q;
	logic             exp_over;
	logic             exp_under;

	// difference indicators, latched once per add or subtract
	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			g <= 1'b0;
			wdt <= 1'b0;
			wt <= 1'b0;
			align_q <= '0;
		end else if (ctl.clr) begin
			g <= 1'b0;
			wdt <= 1'b0;
			wt <= 1'b0;
			align_q <= '0;
		end else if (ctl.ind_strobe) begin
			g <= ge_limit;
			wdt <= diff_neg;
			// result is the first argument
			wt <= ge_limit & ~diff_neg;
			align_q <= ge_limit ? '0 : diff_abs;
		end
	end

	// top three bits of D give the range of the 10-bit exponent
	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			exp_over <= 1'b0;
			exp_under <= 1'b0;
		end else if (ctl.clr) begin
			exp_over <= 1'b0;
			exp_under <= 1'b0;
		end else if (ctl.range_strobe) begin
			exp_over <= ~d[9] & (d[8] | d[7]);
			exp_under <= d[9] & ~(d[8] & d[7]);
		end
	end

	always_comb begin
		res.exp = d;
		res.align = ALIGN_W'(align_q);
		res.g = g;
		res.wdt = wdt;
		res.wt = wt;
		res.exp_over = exp_over;
		res.exp_under = exp_under;
	end

endmodule

// File: logic/fpm_fic.sv
// ---------------------------------------------------------------------------
// alignment shift counter
// loadable down-counter with look-ahead zero flag
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module fpm_fic import fpm_pkg::*; #(
	parameter int FIC_W = 6
) (
	input  logic             clk_sys,
	input  logic             _0_f,
	input  fpm_ctl_t         ctl,
	input  logic [FIC_W-1:0] load_val,
	output logic             fic_zero
);

	logic [FIC_W-1:0] cnt;
	logic [FIC_W-1:0] cnt_next;

	always_comb begin
		cnt_next = cnt;
		if (ctl.fic_load)
			cnt_next = load_val;
		else if (ctl.fic_step)
			cnt_next = cnt - FIC_W'(1);
	end

	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f)
			cnt <= '0;
		else
			cnt <= cnt_next;
	end

	// zero after this clock, so the sequencer leaves ALIGN on the last step
	assign fic_zero = (cnt_next == '0);

	// the sequencer must never step an empty counter
	a_no_step_at_zero: assert property (@(posedge clk_sys) disable iff (_0_f)
		ctl.fic_step |-> (cnt != '0));

endmodule

// File: logic/fpm_exp_path.sv
// ---------------------------------------------------------------------------
// exponent datapath
// L bus mux, D and B registers, B bus function mux
// 10-bit exponent adder and alignment limit compare
// ---------------------------------------------------------------------------

`timescale 1ns/1ps

module fpm_exp_path import fpm_pkg::*; #(
	parameter int ALIGN_LIMIT = 40,
	parameter int FIC_W = 6
) (
	input  logic              clk_sys,
	input  logic              _0_f,
	input  fpm_cmd_t          cmd,
	input  fpm_ctl_t          ctl,
	output logic signed [9:0] d,
	output logic              diff_neg,
	output logic [FIC_W-1:0]  diff_abs,
	output logic              ge_limit
);

	localparam logic [9:0] LIMIT = 10'(ALIGN_LIMIT);

	logic              sel_b;
	logic signed [7:0] opnd;
	logic signed [9:0] l_bus;
	logic signed [9:0] b;
	logic [9:0]        b_bus;
	logic [9:0]        sum;
	logic [9:0]        mag;

	// a plain operand load outside the B transfer takes the larger exponent
	// when D holds a negative difference
	assign sel_b = ctl.opnd_b | (~ctl.l_b & d[9]);
	assign opnd = sel_b ? cmd.exp_b : cmd.exp_a;

	always_comb begin
		case (ctl.lkb)
			1'b0: l_bus = sum;
			1'b1: l_bus = {opnd[7], opnd[7], opnd};
		endcase
	end

	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f)
			d <= '0;
		else if (ctl.l_d)
			d <= l_bus;
	end

	// B keeps the second exponent
	always_ff @(posedge clk_sys) begin
		if (ctl.l_b)
			b <= d;
	end

	always_comb begin
		case (ctl.bsel)
			BB_INV:  b_bus = ~b;
			BB_TRUE: b_bus = b;
			BB_ONES: b_bus = {10{1'b1}};
			BB_ZERO: b_bus = '0;
		endcase
	end

	assign sum = d + b_bus + 10'(ctl.pc8);

	// sign and magnitude of the difference
	assign diff_neg = sum[9];
	assign mag = sum[9] ? (~sum + 10'd1) : sum;
	assign diff_abs = mag[FIC_W-1:0];
	assign ge_limit = (mag >= LIMIT);

	// the B transfer and the sum load must be in different phases
	a_no_lb_on_sum: assert property (@(posedge clk_sys) disable iff (_0_f)
		!(ctl.l_b && ctl.l_d && !ctl.lkb));

endmodule

// File: logic/fpm_pkg.sv
// ---------------------------------------------------------------------------
// shared types of the F-PM exponent and control unit
// operation and B-bus function enums
// command, result and control structs
// ---------------------------------------------------------------------------

package fpm_pkg;

	// width of the alignment count in the result
	localparam int ALIGN_W = 6;

	// floating operations handled by the unit
	typedef enum logic [1:0] {
		OP_AF = 2'd0,
		OP_SF = 2'd1,
		OP_MF = 2'd2,
		OP_DF = 2'd3
	} fp_op_e;

	// B bus function, same coding as the fcb/scc pair
	typedef enum logic [1:0] {
		BB_INV  = 2'b00,
		BB_TRUE = 2'b01,
		BB_ONES = 2'b10,
		BB_ZERO = 2'b11
	} bbus_e;

	// command from the host, held while req is high
	typedef struct packed {
		fp_op_e            op;
		logic signed [7:0] exp_a;
		logic signed [7:0] exp_b;
	} fpm_cmd_t;

	typedef struct packed {
		logic signed [9:0]   exp;
		logic [ALIGN_W-1:0]  align;
		logic                g;
		logic                wdt;
		logic                wt;
		logic                exp_over;
		logic                exp_under;
	} fpm_res_t;

	// strobes from the sequencer
	typedef struct packed {
		logic  lkb;
		logic  opnd_b;
		logic  l_d;
		logic  l_b;
		bbus_e bsel;
		logic  pc8;
		logic  ind_strobe;
		logic  range_strobe;
		logic  fic_load;
		logic  fic_step;
		logic  clr;
	} fpm_ctl_t;

endpackage
